// File: backend_pkg.sv
`default_nettype none

package backend_pkg;

	localparam int XLEN = 32;

	// integer ALU operations, operand k is rk or the immediate
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLTU = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		ALU_SRA  = 4'd9,
		ALU_LUI  = 4'd10  // imm[19:0] into the upper bits
	} alu_op_t;

	// word-wide memory accesses only
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_op_t;

	typedef enum logic [1:0] {
		WB_NONE = 2'd0,
		WB_ALU  = 2'd1,
		WB_MEM  = 2'd2
	} wb_sel_t;

	// one-hot forwarding source, all zero keeps the register value
	typedef logic [2:0] fwd_sel_t;

	localparam fwd_sel_t FWD_NONE = 3'b000;
	localparam fwd_sel_t FWD_M1   = 3'b001;
	localparam fwd_sel_t FWD_M2   = 3'b010;
	localparam fwd_sel_t FWD_WB   = 3'b100;

endpackage : backend_pkg

`default_nettype wire

// File: forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
	input  var backend_pkg::fwd_sel_t        sel_i,
	input  wire [backend_pkg::XLEN-1:0]      m1_i,
	input  wire [backend_pkg::XLEN-1:0]      m2_i,
	input  wire [backend_pkg::XLEN-1:0]      wb_i,
	input  wire [backend_pkg::XLEN-1:0]      reg_i,
	output logic [backend_pkg::XLEN-1:0]     data_o
);
	import backend_pkg::*;

	always_comb begin
		case (sel_i)
			FWD_M1:  data_o = m1_i;
			FWD_M2:  data_o = m2_i;
			FWD_WB:  data_o = wb_i;
			default: data_o = reg_i;  // no producer in flight
		endcase
	end

	// issuer must never name two producers at once
	always_comb begin
		assert ($onehot0(sel_i))
			else $error("forwarding select %b is not one-hot", sel_i);
	end

endmodule : forwarding_unit

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  var backend_pkg::alu_op_t     op_i,
	input  wire [backend_pkg::XLEN-1:0]  a_i,
	input  wire [backend_pkg::XLEN-1:0]  b_i,
	output logic [backend_pkg::XLEN-1:0] res_o
);
	import backend_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = b_i[4:0];
	assign lt_signed   = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;

	always_comb begin
		case (op_i)
			ALU_ADD:  res_o = a_i + b_i;
			ALU_SUB:  res_o = a_i - b_i;
			ALU_AND:  res_o = a_i & b_i;
			ALU_OR:   res_o = a_i | b_i;
			ALU_XOR:  res_o = a_i ^ b_i;
			ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			ALU_SLL:  res_o = a_i << shamt;
			ALU_SRL:  res_o = a_i >> shamt;
			ALU_SRA:  res_o = $signed(a_i) >>> shamt;
			// low 20 bits of operand k land in the upper part
			ALU_LUI:  res_o = {b_i[19:0], 12'd0};
			default:  res_o = '0;  // unused encodings
		endcase
	end

endmodule : alu

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire [4:0]                    rj_i,
	input  wire [4:0]                    rk_i,
	input  wire                          we_i,
	input  wire [4:0]                    waddr_i,
	input  wire [backend_pkg::XLEN-1:0]  wdata_i,
	output logic [backend_pkg::XLEN-1:0] rj_data_o,
	output logic [backend_pkg::XLEN-1:0] rk_data_o
);
	import backend_pkg::*;

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != 5'd0) begin  // r0 never written
			regs[waddr_i] <= wdata_i;
		end
	end

	// reads see a same-cycle write from WB
	always_comb begin
		if (rj_i == 5'd0)
			rj_data_o = '0;
		else if (we_i && waddr_i == rj_i)
			rj_data_o = wdata_i;
		else
			rj_data_o = regs[rj_i];
	end

	always_comb begin
		if (rk_i == 5'd0)
			rk_data_o = '0;
		else if (we_i && waddr_i == rk_i)
			rk_data_o = wdata_i;
		else
			rk_data_o = regs[rk_i];
	end

endmodule : regfile

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          issue_i,
	input  wire                          stall_i,
	input  wire                          flush_i,
	input  var backend_pkg::alu_op_t     alu_op_i,
	input  var backend_pkg::mem_op_t     mem_op_i,
	input  var backend_pkg::wb_sel_t     wb_sel_i,
	input  wire                          use_imm_i,
	input  wire [4:0]                    rd_i,
	input  wire [backend_pkg::XLEN-1:0]  imm_i,
	input  var backend_pkg::fwd_sel_t    fwd_j_i,
	input  var backend_pkg::fwd_sel_t    fwd_k_i,
	input  wire [backend_pkg::XLEN-1:0]  rj_data_i,
	input  wire [backend_pkg::XLEN-1:0]  rk_data_i,
	input  wire [backend_pkg::XLEN-1:0]  m1_result_i,
	input  wire [backend_pkg::XLEN-1:0]  m2_result_i,
	input  wire [backend_pkg::XLEN-1:0]  wb_result_i,
	input  wire                          m1_is_load_i,
	output logic                         ex_valid_o,
	output logic [4:0]                   ex_rd_o,
	output backend_pkg::wb_sel_t         ex_wb_sel_o,
	output backend_pkg::mem_op_t         ex_mem_op_o,
	output logic [backend_pkg::XLEN-1:0] ex_result_o,
	output logic [backend_pkg::XLEN-1:0] ex_addr_o,
	output logic [backend_pkg::XLEN-1:0] ex_store_data_o
);
	import backend_pkg::*;

	logic            valid_q;
	fwd_sel_t        fwd_j_q, fwd_k_q;
	alu_op_t         alu_op_q;
	mem_op_t         mem_op_q;
	wb_sel_t         wb_sel_q;
	logic            use_imm_q;
	logic [4:0]      rd_q;
	logic [XLEN-1:0] imm_q;
	logic [XLEN-1:0] rj_q, rk_q;      // raw register values
	logic [XLEN-1:0] rj_fwd, rk_fwd;  // after forwarding
	logic [XLEN-1:0] alu_b;

	// control part of the EX register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			fwd_j_q <= FWD_NONE;
			fwd_k_q <= FWD_NONE;
		end else if (flush_i) begin
			valid_q <= 1'b0;
			fwd_j_q <= FWD_NONE;
			fwd_k_q <= FWD_NONE;
		end else if (stall_i) begin
			// operands were captured below, sources no longer needed
			fwd_j_q <= FWD_NONE;
			fwd_k_q <= FWD_NONE;
		end else begin
			valid_q <= issue_i;
			fwd_j_q <= issue_i ? fwd_j_i : FWD_NONE;
			fwd_k_q <= issue_i ? fwd_k_i : FWD_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (stall_i) begin
			rj_q <= rj_fwd;
			rk_q <= rk_fwd;
		end else begin
			alu_op_q  <= alu_op_i;
			mem_op_q  <= mem_op_i;
			wb_sel_q  <= wb_sel_i;
			use_imm_q <= use_imm_i;
			rd_q      <= rd_i;
			imm_q     <= imm_i;
			rj_q      <= rj_data_i;
			rk_q      <= rk_data_i;
		end
	end

	forwarding_unit i_fwd_j (
		.sel_i  (fwd_j_q),
		.m1_i   (m1_result_i),
		.m2_i   (m2_result_i),
		.wb_i   (wb_result_i),
		.reg_i  (rj_q),
		.data_o (rj_fwd)
	);

	forwarding_unit i_fwd_k (
		.sel_i  (fwd_k_q),
		.m1_i   (m1_result_i),
		.m2_i   (m2_result_i),
		.wb_i   (wb_result_i),
		.reg_i  (rk_q),
		.data_o (rk_fwd)
	);

	assign alu_b = use_imm_q ? imm_q : rk_fwd;

	alu i_alu (
		.op_i  (alu_op_q),
		.a_i   (rj_fwd),
		.b_i   (alu_b),
		.res_o (ex_result_o)
	);

	assign ex_valid_o      = valid_q;
	assign ex_rd_o         = rd_q;
	assign ex_wb_sel_o     = wb_sel_q;
	assign ex_mem_op_o     = mem_op_q;
	assign ex_addr_o       = rj_fwd + imm_q;  // word address generation
	assign ex_store_data_o = rk_fwd;

	// load data only exists from M2 on, the issuer leaves a gap
	a_no_m1_load_fwd: assert property (@(posedge clk) disable iff (!rst_n)
		valid_q && (fwd_j_q[0] || fwd_k_q[0]) |-> !m1_is_load_i)
		else $error("M1 forwarding select points at a load");

endmodule : ex_stage

`default_nettype wire

// File: mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage #(
	parameter int DMEM_DEPTH = 64
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          stall_i,
	input  wire                          flush_i,
	input  wire                          ex_valid_i,
	input  wire [4:0]                    ex_rd_i,
	input  var backend_pkg::wb_sel_t     ex_wb_sel_i,
	input  var backend_pkg::mem_op_t     ex_mem_op_i,
	input  wire [backend_pkg::XLEN-1:0]  ex_result_i,
	input  wire [backend_pkg::XLEN-1:0]  ex_addr_i,
	input  wire [backend_pkg::XLEN-1:0]  ex_store_data_i,
	output logic [backend_pkg::XLEN-1:0] m1_result_o,
	output logic                         m1_is_load_o,
	output logic [backend_pkg::XLEN-1:0] m2_result_o,
	output logic [backend_pkg::XLEN-1:0] wb_result_o,
	output logic                         reg_w_en_o,
	output logic [4:0]                   reg_w_addr_o,
	output logic [backend_pkg::XLEN-1:0] reg_w_data_o
);
	import backend_pkg::*;

	localparam int AW = $clog2(DMEM_DEPTH);

	logic [XLEN-1:0] dmem [DMEM_DEPTH];

	logic            m1_valid_q, m2_valid_q, wb_valid_q;
	logic [4:0]      m1_rd_q, m2_rd_q, wb_rd_q;
	wb_sel_t         m1_wb_sel_q, m2_wb_sel_q, wb_wb_sel_q;
	mem_op_t         m1_mem_op_q;
	logic [XLEN-1:0] m1_result_q, m1_addr_q, m1_store_data_q;
	logic [XLEN-1:0] m2_result_q, m2_load_q;
	logic [XLEN-1:0] wb_result_q;
	logic [AW-1:0]   m1_idx;
	logic            store_en;

	assign m1_idx   = m1_addr_q[AW+1:2];
	// store commits on the edge that moves it out of M1
	assign store_en = m1_valid_q && m1_mem_op_q == MEM_STORE && !stall_i && !flush_i;

	// valid bits, flush kills whatever sits in EX and M1
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_valid_q <= 1'b0;
			m2_valid_q <= 1'b0;
			wb_valid_q <= 1'b0;
		end else begin
			if (flush_i)
				m1_valid_q <= 1'b0;
			else if (!stall_i)
				m1_valid_q <= ex_valid_i;
			if (!stall_i)
				m2_valid_q <= m1_valid_q && !flush_i;
			wb_valid_q <= m2_valid_q && !stall_i;  // bubble while stalled
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			m1_rd_q         <= ex_rd_i;
			m1_wb_sel_q     <= ex_wb_sel_i;
			m1_mem_op_q     <= ex_mem_op_i;
			m1_result_q     <= ex_result_i;
			m1_addr_q       <= ex_addr_i;
			m1_store_data_q <= ex_store_data_i;
			m2_rd_q         <= m1_rd_q;
			m2_wb_sel_q     <= m1_wb_sel_q;
			m2_result_q     <= m1_result_q;
			m2_load_q       <= dmem[m1_idx];  // load read at M1 -> M2
		end
		wb_rd_q     <= m2_rd_q;
		wb_wb_sel_q <= m2_wb_sel_q;
		wb_result_q <= m2_result_o;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (store_en) begin
			dmem[m1_idx] <= m1_store_data_q;
		end
	end

	assign m1_result_o  = m1_result_q;
	assign m1_is_load_o = m1_valid_q && m1_mem_op_q == MEM_LOAD;
	assign m2_result_o  = (m2_wb_sel_q == WB_MEM) ? m2_load_q : m2_result_q;
	assign wb_result_o  = wb_result_q;

	assign reg_w_en_o   = wb_valid_q && wb_wb_sel_q != WB_NONE && wb_rd_q != 5'd0;
	assign reg_w_addr_o = wb_rd_q;
	assign reg_w_data_o = wb_result_q;

	// address was formed in EX, checked where the RAM is used
	a_dmem_addr: assert property (@(posedge clk) disable iff (!rst_n)
		m1_valid_q && m1_mem_op_q != MEM_NONE |->
			m1_addr_q[1:0] == 2'b00 && (m1_addr_q >> 2) < DMEM_DEPTH)
		else $error("data address %h misaligned or out of range", m1_addr_q);

endmodule : mem_wb_stage

`default_nettype wire

// File: backend_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module backend_pipeline #(
	parameter int DMEM_DEPTH = 64
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          issue_i,
	input  wire                          stall_i,
	input  wire                          flush_i,
	input  var backend_pkg::alu_op_t     alu_op_i,
	input  var backend_pkg::mem_op_t     mem_op_i,
	input  var backend_pkg::wb_sel_t     wb_sel_i,
	input  wire                          use_imm_i,
	input  wire [4:0]                    rd_i,
	input  wire [4:0]                    rj_i,
	input  wire [4:0]                    rk_i,
	input  wire [backend_pkg::XLEN-1:0]  imm_i,
	input  var backend_pkg::fwd_sel_t    fwd_j_i,
	input  var backend_pkg::fwd_sel_t    fwd_k_i,
	output logic                         reg_w_en_o,
	output logic [4:0]                   reg_w_addr_o,
	output logic [backend_pkg::XLEN-1:0] reg_w_data_o
);
	import backend_pkg::*;

	logic [XLEN-1:0] rj_data, rk_data;
	logic            ex_valid;
	logic [4:0]      ex_rd;
	wb_sel_t         ex_wb_sel;
	mem_op_t         ex_mem_op;
	logic [XLEN-1:0] ex_result, ex_addr, ex_store_data;
	logic [XLEN-1:0] m1_result, m2_result, wb_result;  // forwarding sources
	logic            m1_is_load;

	regfile i_regfile (
		.clk       (clk),
		.rst_n     (rst_n),
		.rj_i      (rj_i),
		.rk_i      (rk_i),
		.we_i      (reg_w_en_o),
		.waddr_i   (reg_w_addr_o),
		.wdata_i   (reg_w_data_o),
		.rj_data_o (rj_data),
		.rk_data_o (rk_data)
	);

	ex_stage i_ex (
		.clk             (clk),
		.rst_n           (rst_n),
		.issue_i         (issue_i),
		.stall_i         (stall_i),
		.flush_i         (flush_i),
		.alu_op_i        (alu_op_i),
		.mem_op_i        (mem_op_i),
		.wb_sel_i        (wb_sel_i),
		.use_imm_i       (use_imm_i),
		.rd_i            (rd_i),
		.imm_i           (imm_i),
		.fwd_j_i         (fwd_j_i),
		.fwd_k_i         (fwd_k_i),
		.rj_data_i       (rj_data),
		.rk_data_i       (rk_data),
		.m1_result_i     (m1_result),
		.m2_result_i     (m2_result),
		.wb_result_i     (wb_result),
		.m1_is_load_i    (m1_is_load),
		.ex_valid_o      (ex_valid),
		.ex_rd_o         (ex_rd),
		.ex_wb_sel_o     (ex_wb_sel),
		.ex_mem_op_o     (ex_mem_op),
		.ex_result_o     (ex_result),
		.ex_addr_o       (ex_addr),
		.ex_store_data_o (ex_store_data)
	);

	mem_wb_stage #(
		.DMEM_DEPTH (DMEM_DEPTH)
	) i_mem_wb (
		.clk             (clk),
		.rst_n           (rst_n),
		.stall_i         (stall_i),
		.flush_i         (flush_i),
		.ex_valid_i      (ex_valid),
		.ex_rd_i         (ex_rd),
		.ex_wb_sel_i     (ex_wb_sel),
		.ex_mem_op_i     (ex_mem_op),
		.ex_result_i     (ex_result),
		.ex_addr_i       (ex_addr),
		.ex_store_data_i (ex_store_data),
		.m1_result_o     (m1_result),
		.m1_is_load_o    (m1_is_load),
		.m2_result_o     (m2_result),
		.wb_result_o     (wb_result),
		.reg_w_en_o      (reg_w_en_o),
		.reg_w_addr_o    (reg_w_addr_o),
		.reg_w_data_o    (reg_w_data_o)
	);

endmodule : backend_pipeline

`default_nettype wire

// File: backend_pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module backend_pipeline_tb;
	import backend_pkg::*;

	localparam int MAX_ROWS = 160;
	localparam int N_TESTS  = 6;

	logic            clk, rst_n, issue_i, stall_i, flush_i, use_imm_i;
	alu_op_t         alu_op_i;
	mem_op_t         mem_op_i;
	wb_sel_t         wb_sel_i;
	logic [4:0]      rd_i, rj_i, rk_i;
	logic [XLEN-1:0] imm_i;
	fwd_sel_t        fwd_j_i, fwd_k_i;
	logic            reg_w_en_o;
	logic [4:0]      reg_w_addr_o;
	logic [XLEN-1:0] reg_w_data_o;

	// stimulus table with one row per cycle
	bit              t_issue[MAX_ROWS], t_use_imm[MAX_ROWS], t_stall[MAX_ROWS], t_flush[MAX_ROWS];
	alu_op_t         t_alu[MAX_ROWS];
	mem_op_t         t_mem[MAX_ROWS];
	wb_sel_t         t_wb[MAX_ROWS];
	logic [4:0]      t_rd[MAX_ROWS], t_rj[MAX_ROWS], t_rk[MAX_ROWS];
	logic [XLEN-1:0] t_imm[MAX_ROWS];
	fwd_sel_t        t_fj[MAX_ROWS], t_fk[MAX_ROWS];
	int              t_test[MAX_ROWS];
	int              n_rows = 0;
	bit              table_ready = 0;

	// expected register writes in order
	int              exp_cycle[$], exp_test[$];
	logic [4:0]      exp_rd[$];
	logic [XLEN-1:0] exp_data[$];
	int              fin[N_TESTS+1], errs[N_TESTS+1];
	int              n_checks = 0, n_errors = 0, cur_test = 0;

	backend_pipeline #(.DMEM_DEPTH(64)) i_dut (
		.clk(clk), .rst_n(rst_n), .issue_i(issue_i), .stall_i(stall_i), .flush_i(flush_i),
		.alu_op_i(alu_op_i), .mem_op_i(mem_op_i), .wb_sel_i(wb_sel_i), .use_imm_i(use_imm_i),
		.rd_i(rd_i), .rj_i(rj_i), .rk_i(rk_i), .imm_i(imm_i),
		.fwd_j_i(fwd_j_i), .fwd_k_i(fwd_k_i),
		.reg_w_en_o(reg_w_en_o), .reg_w_addr_o(reg_w_addr_o), .reg_w_data_o(reg_w_data_o)
	);

	always #5 clk = ~clk;

	task automatic add_row(input int test, input alu_op_t op, input mem_op_t mem,
		input wb_sel_t wb, input bit use_imm, input int rd, input int rj, input int rk,
		input logic [XLEN-1:0] imm, input fwd_sel_t fj, input fwd_sel_t fk);
		t_issue[n_rows] = 1;
		t_alu[n_rows] = op;
		t_mem[n_rows] = mem;
		t_wb[n_rows] = wb;
		t_use_imm[n_rows] = use_imm;
		t_rd[n_rows] = rd[4:0];
		t_rj[n_rows] = rj[4:0];
		t_rk[n_rows] = rk[4:0];
		t_imm[n_rows] = imm;
		t_fj[n_rows] = fj;
		t_fk[n_rows] = fk;
		t_stall[n_rows] = 0;
		t_flush[n_rows] = 0;
		t_test[n_rows] = test;
		n_rows++;
	endtask

	task automatic add_idle(input int test, input int count, input bit stall);
		repeat (count) begin
			add_row(test, ALU_ADD, MEM_NONE, WB_NONE, 0, 0, 0, 0, '0, FWD_NONE, FWD_NONE);
			t_issue[n_rows-1] = 0;
			t_stall[n_rows-1] = stall;
		end
	endtask

	// rd = r0 + imm through the alu
	task automatic add_li(input int test, input int rd, input logic [XLEN-1:0] imm);
		add_row(test, ALU_ADD, MEM_NONE, WB_ALU, 1, rd, 0, 0, imm, FWD_NONE, FWD_NONE);
	endtask

	function automatic logic [XLEN-1:0] calc_alu(alu_op_t op, logic [XLEN-1:0] a,
		logic [XLEN-1:0] b);
		logic signed [XLEN-1:0] sa;
		sa = a;
		case (op)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			ALU_SRA:  return sa >>> b[4:0];
			ALU_LUI:  return {b[19:0], 12'd0};
			default:  return '0;
		endcase
	endfunction

	// architectural model run over the table in issue order
	task automatic compute_expected();
		logic [XLEN-1:0] mregs[32];
		logic [XLEN-1:0] mmem[64];
		logic [XLEN-1:0] a, b, res, addr;
		bit              squashed[MAX_ROWS];
		int              stage, j;
		for (int i = 0; i < 32; i++) mregs[i] = '0;
		for (int i = 0; i < 64; i++) mmem[i] = '0;
		for (int i = 0; i < n_rows; i++) begin
			if (t_flush[i]) begin  // flush kills EX, M1 and the row itself
				squashed[i] = 1;
				if (i >= 1) squashed[i-1] = 1;
				if (i >= 2) squashed[i-2] = 1;
			end
		end
		for (int i = 0; i < n_rows; i++) begin
			if (fin[t_test[i]] < i + 1) fin[t_test[i]] = i + 1;
			if (!t_issue[i] || squashed[i]) continue;
			a = mregs[t_rj[i]];
			b = t_use_imm[i] ? t_imm[i] : mregs[t_rk[i]];
			res = calc_alu(t_alu[i], a, b);
			addr = a + t_imm[i];
			if (t_mem[i] == MEM_STORE) mmem[addr[7:2]] = mregs[t_rk[i]];
			if (t_wb[i] == WB_MEM) res = mmem[addr[7:2]];
			if (t_wb[i] == WB_NONE || t_rd[i] == 0) continue;
			mregs[t_rd[i]] = res;
			// in EX after edge i and one stage per unstalled edge
			stage = 1;
			j = i + 1;
			while (stage < 4) begin
				if (j >= n_rows || !t_stall[j]) stage++;
				j++;
			end
			exp_cycle.push_back(j);
			exp_rd.push_back(t_rd[i]);
			exp_data.push_back(res);
			exp_test.push_back(t_test[i]);
			if (fin[t_test[i]] < j) fin[t_test[i]] = j;
		end
	endtask

	task automatic check_outputs(input int k);
		int t;
		while (exp_cycle.size() > 0 &&
			(exp_cycle[0] < k || (exp_cycle[0] == k && !reg_w_en_o))) begin
			t = exp_test.pop_front();
			$display("missing write to r%0d in test %0d", exp_rd.pop_front(), t);
			void'(exp_cycle.pop_front());
			void'(exp_data.pop_front());
			errs[t]++;
			n_errors++;
		end
		if (reg_w_en_o) begin
			if (exp_cycle.size() == 0 || exp_cycle[0] != k) begin
				$display("unexpected write to r%0d at %0t", reg_w_addr_o, $time);
				errs[cur_test]++;
				n_errors++;
			end else begin
				t = exp_test.pop_front();
				void'(exp_cycle.pop_front());
				n_checks++;
				if (reg_w_addr_o != exp_rd[0]) begin
					$display("Error at %0t: reg_w_addr_o expected %0d got %0d",
						$time, exp_rd[0], reg_w_addr_o);
					errs[t]++;
					n_errors++;
				end
				if (reg_w_data_o != exp_data[0]) begin
					$display("Error at %0t: reg_w_data_o expected %h got %h",
						$time, exp_data[0], reg_w_data_o);
					errs[t]++;
					n_errors++;
				end
				void'(exp_rd.pop_front());
				void'(exp_data.pop_front());
			end
		end
		for (int i = 1; i <= N_TESTS; i++) begin
			if (fin[i] == k) $display("test %0d finished, %0d errors", i, errs[i]);
		end
	endtask

	task automatic drive_row(input int i);
		issue_i = t_issue[i];
		stall_i = t_stall[i];
		flush_i = t_flush[i];
		alu_op_i = t_alu[i];
		mem_op_i = t_mem[i];
		wb_sel_i = t_wb[i];
		use_imm_i = t_use_imm[i];
		rd_i = t_rd[i];
		rj_i = t_rj[i];
		rk_i = t_rk[i];
		imm_i = t_imm[i];
		fwd_j_i = t_fj[i];
		fwd_k_i = t_fk[i];
		cur_test = t_test[i];
	endtask

	task automatic drive_idle();
		issue_i = 0;
		stall_i = 0;
		flush_i = 0;
		fwd_j_i = FWD_NONE;
		fwd_k_i = FWD_NONE;
	endtask

	task automatic build_table();
		alu_op_t ops[11];
		ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
			ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI};
		// test 1 loads random operands plus a negative and a small shift amount
		for (int r = 1; r <= 6; r++) add_li(1, r, $urandom);
		add_li(1, 7, 32'hffff_fffb);
		add_li(1, 8, 32'd3);
		add_idle(1, 3, 0);
		// test 2 runs each op on registers and on the immediate
		for (int o = 0; o < 11; o++) begin
			add_row(2, ops[o], MEM_NONE, WB_ALU, ops[o] == ALU_LUI, 10 + o,
				(o >= 5) ? 7 : 1, (o >= 5) ? 8 : 2, 32'h000a_bcde, FWD_NONE, FWD_NONE);
			add_idle(2, 3, 0);
			if (ops[o] != ALU_LUI) begin
				add_row(2, ops[o], MEM_NONE, WB_ALU, 1, 10 + o, (o >= 5) ? 7 : 1, 0,
					32'h000a_bcde, FWD_NONE, FWD_NONE);
				add_idle(2, 3, 0);
			end
		end
		add_row(2, ALU_XOR, MEM_NONE, WB_ALU, 1, 21, 3, 0, 32'h0f0f_0f0f, FWD_NONE, FWD_NONE);
		add_idle(2, 3, 0);
		add_row(2, ALU_SLT, MEM_NONE, WB_ALU, 1, 22, 7, 0, 32'hffff_fff0, FWD_NONE, FWD_NONE);
		add_idle(2, 3, 0);
		// test 3 is a dependent chain through M1, M2 and WB
		add_row(3, ALU_ADD, MEM_NONE, WB_ALU, 1, 21, 1, 0, 32'd5, FWD_NONE, FWD_NONE);
		add_row(3, ALU_ADD, MEM_NONE, WB_ALU, 0, 22, 21, 2, '0, FWD_M1, FWD_NONE);
		add_row(3, ALU_SUB, MEM_NONE, WB_ALU, 0, 23, 22, 21, '0, FWD_M1, FWD_M2);
		add_row(3, ALU_XOR, MEM_NONE, WB_ALU, 0, 24, 21, 23, '0, FWD_WB, FWD_M1);
		add_idle(3, 3, 0);
		// test 4 has a store and a load, a consumer on M2 and a write to r0
		add_row(4, ALU_ADD, MEM_STORE, WB_NONE, 0, 0, 0, 24, 32'h10, FWD_NONE, FWD_NONE);
		add_row(4, ALU_ADD, MEM_LOAD, WB_MEM, 0, 25, 0, 0, 32'h10, FWD_NONE, FWD_NONE);
		add_idle(4, 1, 0);
		add_row(4, ALU_ADD, MEM_NONE, WB_ALU, 0, 26, 25, 8, '0, FWD_M2, FWD_NONE);
		add_row(4, ALU_ADD, MEM_NONE, WB_ALU, 1, 0, 1, 0, 32'd9, FWD_NONE, FWD_NONE);
		add_idle(4, 3, 0);
		// test 5 puts stalls of 2, 1 and 3 cycles inside a chain
		add_row(5, ALU_ADD, MEM_NONE, WB_ALU, 1, 27, 1, 0, 32'd1, FWD_NONE, FWD_NONE);
		add_idle(5, 2, 1);
		add_row(5, ALU_ADD, MEM_NONE, WB_ALU, 1, 28, 27, 0, 32'd1, FWD_M1, FWD_NONE);
		add_idle(5, 1, 1);
		add_row(5, ALU_ADD, MEM_NONE, WB_ALU, 0, 29, 28, 27, '0, FWD_M1, FWD_M2);
		add_idle(5, 3, 1);
		add_row(5, ALU_ADD, MEM_NONE, WB_ALU, 1, 30, 29, 0, 32'd7, FWD_M1, FWD_NONE);
		add_idle(5, 3, 0);
		// test 6 stores an old word at 0x20 before a flush kills two ops and a store
		add_row(6, ALU_ADD, MEM_STORE, WB_NONE, 0, 0, 0, 1, 32'h20, FWD_NONE, FWD_NONE);
		add_idle(6, 3, 0);
		add_li(6, 3, 32'h111);
		add_row(6, ALU_ADD, MEM_STORE, WB_NONE, 0, 0, 0, 2, 32'h20, FWD_NONE, FWD_NONE);
		add_li(6, 4, 32'h222);
		t_flush[n_rows-1] = 1;
		add_idle(6, 2, 0);
		add_row(6, ALU_ADD, MEM_LOAD, WB_MEM, 0, 5, 0, 0, 32'h20, FWD_NONE, FWD_NONE);
		add_idle(6, 4, 0);
	endtask

	initial begin
		wait (table_ready);
		#((n_rows + 20) * 10);
		$display("timeout after %0d rows, run stopped", n_rows);
		$display("Verification failed");
		$finish;
	end

	initial begin
		clk = 0;
		rst_n = 0;
		alu_op_i = ALU_ADD;
		mem_op_i = MEM_NONE;
		wb_sel_i = WB_NONE;
		use_imm_i = 0;
		rd_i = '0;
		rj_i = '0;
		rk_i = '0;
		imm_i = '0;
		drive_idle();
		void'($urandom(32'hea4dfd55));
		for (int i = 0; i <= N_TESTS; i++) begin
			fin[i] = -1;
			errs[i] = 0;
		end
		build_table();
		compute_expected();
		table_ready = 1;
		repeat (4) begin
			@(negedge clk);
			if (reg_w_en_o) begin
				$display("write enable raised during reset");
				n_errors++;
			end
		end
		rst_n = 1;
		for (int i = 0; i < n_rows; i++) begin
			@(negedge clk);
			check_outputs(i);
			drive_row(i);
		end
		for (int k = n_rows; k < n_rows + 8; k++) begin
			@(negedge clk);
			check_outputs(k);
			drive_idle();
		end
		if (exp_cycle.size() > 0) begin
			$display("%0d expected writes never appeared", exp_cycle.size());
			n_errors += exp_cycle.size();
		end
		$display("tests: %0d, writes checked: %0d, errors: %0d", N_TESTS, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule : backend_pipeline_tb

`default_nettype wire

// File: backend_pipeline.f
backend_pkg.sv
forwarding_unit.sv
alu.sv
regfile.sv
ex_stage.sv
mem_wb_stage.sv
backend_pipeline.sv
backend_pipeline_tb.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module backend_pipeline_tb \
	-f backend_pipeline.f -o sim > build.log 2>&1 &&
./obj_dir/sim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 ||
grep -q "Verification passed" sim.log || exit 1
exit 0
